// File: cpuPkg.sv
package cpuPkg;

    //////////////////////////////////////////////////
    // widths and constants
    //////////////////////////////////////////////////
    localparam int XLEN = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    // addi x0,x0,0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    typedef logic [XLEN-1:0] Word;
    typedef logic [REG_ADDR_W-1:0] RegAddr;

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////
    // major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } Opcode;

    typedef enum logic [2:0] {
        ALU, ALUI, LUI, JAL, BRANCH, LOAD, STORE, UNSUPPORTED
    } IType;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } AluFunc;

    typedef enum logic [1:0] {BR_EQ, BR_NE, BR_LT, BR_GE} BrFunc;

    typedef enum logic [1:0] {DEQUEUE, STALL, REDIRECT} FetchAction;

    //////////////////////////////////////////////////
    // stage bundles
    //////////////////////////////////////////////////
    typedef struct packed {
        FetchAction action;
        // only meaningful with REDIRECT
        Word redirectPc;
    } FetchCmd;

    typedef struct packed {
        Word pc;
        Word instr;
        logic valid;
    } F2D;

    typedef struct packed {
        IType iType;
        AluFunc aluFunc;
        BrFunc brFunc;
        RegAddr dst;
        RegAddr src1;
        RegAddr src2;
        Word imm;
    } DecodedInst;

    typedef struct packed {
        Word pc;
        DecodedInst dInst;
        Word rVal1;
        Word rVal2;
        logic valid;
    } D2E;

    typedef struct packed {
        IType iType;
        RegAddr dst;
        Word data;
        logic valid;
    } E2W;

    // dst of zero means nothing to forward
    typedef struct packed {
        RegAddr dst;
        Word data;
        logic dataValid;
    } Bypass;

    typedef struct packed {
        logic en;
        RegAddr addr;
        Word data;
    } RfWrite;

    typedef struct packed {
        Word addr;
        Word writeData;
        logic dispatchRead;
        logic dispatchWrite;
    } DmemReq;

endpackage

// File: cpuTb.sv
module cpuTb;
    timeunit 1ns;
    timeprecision 1ps;

    import cpuPkg::*;

    //////////////////////////////////////////////////
    // test sizes and memory map
    //////////////////////////////////////////////////
    localparam int CLK_HALF = 2;
    localparam int CLK_PERIOD = 2 * CLK_HALF;
    localparam int NUM_BASE = 3;
    localparam int NUM_TESTS = 2 * NUM_BASE;
    localparam int PROG_WORDS = 16;
    localparam int MAX_STORES = 4;
    localparam int DMEM_WORDS = 512;
    // pipeline refill cycles added to the worst busy length
    localparam int REFILL_CYCLES = 4;
    localparam int MARGIN = 8;
    localparam int BP_GAP_PCT = 30;
    localparam int BP_BUSY_MAX = 4;
    // end marker, reachable from x0 with a 12-bit offset
    localparam Word DONE_ADDR = 32'h0000_07FC;
    localparam Word DATA_BASE = 32'h0000_0100;
    localparam logic [6:0] I_ARITH = 7'b0010011;
    localparam logic [6:0] I_LOAD = 7'b0000011;

    logic clk_in;
    logic rst_in;
    Word imemAddr;
    logic imemReq;
    Word imemInstr;
    logic imemValid;
    DmemReq dmemReq;
    logic dmemBusy;
    Word dmemReadData;

    // test table
    string testNames [NUM_TESTS];
    Word progs [NUM_TESTS][PROG_WORDS];
    int progLen [NUM_TESTS];
    Word dataInit [NUM_TESTS][2];
    Word expAddr [NUM_TESTS][MAX_STORES];
    Word expData [NUM_TESTS][MAX_STORES];
    int expCount [NUM_TESTS];
    int gapPcts [NUM_TESTS];
    int busyMaxes [NUM_TESTS];
    int buildIdx;

    // run state
    Word imem [PROG_WORDS];
    Word dmem [DMEM_WORDS];
    int curTest;
    int storeIdx;
    int busyLeft;
    Word readLatch;
    logic doneSeen;
    time testStart;
    time testBudget;

    pipelineCpu i_dut (.*);

    // instruction memory answers combinationally, NOP past the program
    assign imemInstr = (imemAddr[31:2] < PROG_WORDS) ? imem[imemAddr[5:2]] : NOP_INSTR;

    initial begin
        clk_in = 1'b0;
        forever #CLK_HALF clk_in = ~clk_in;
    end

    //////////////////////////////////////////////////
    // RV32I encoders
    //////////////////////////////////////////////////
    function automatic Word encodeR(logic [6:0] f7, logic [2:0] f3, RegAddr rd, RegAddr rs1,
                                    RegAddr rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic Word encodeI(logic [6:0] opc, logic [2:0] f3, RegAddr rd, RegAddr rs1,
                                    logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // sw only
    function automatic Word encodeStore(RegAddr rs2, RegAddr rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic Word encodeBranch(logic [2:0] f3, RegAddr rs1, RegAddr rs2,
                                         logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic Word encodeLui(RegAddr rd, logic [19:0] upper);
        return {upper, rd, 7'b0110111};
    endfunction

    function automatic Word encodeJal(RegAddr rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input Word instr);
        progs[buildIdx][progLen[buildIdx]] = instr;
        progLen[buildIdx]++;
    endtask

    task automatic expectStore(input Word addr, input Word data);
        expAddr[buildIdx][expCount[buildIdx]] = addr;
        expData[buildIdx][expCount[buildIdx]] = data;
        expCount[buildIdx]++;
    endtask

    task automatic buildTable();
        for (int t = 0; t < NUM_TESTS; t++) begin
            progLen[t] = 0;
            expCount[t] = 0;
            for (int i = 0; i < PROG_WORDS; i++) begin
                progs[t][i] = NOP_INSTR;
            end
        end
        // dependent chain, each result feeds the next op
        buildIdx = 0;
        testNames[0] = "aluChain";
        dataInit[0] = '{32'h0, 32'h0};
        emit(encodeLui(1, 20'h12345));
        emit(encodeI(I_ARITH, 3'b000, 2, 1, 12'h678));
        emit(encodeI(I_ARITH, 3'b100, 3, 2, 12'hFFF));
        // srai x4,x3,4
        emit(encodeI(I_ARITH, 3'b101, 4, 3, 12'h404));
        emit(encodeR(7'h20, 3'b000, 5, 4, 2));
        emit(encodeStore(5, 0, 12'h200));
        emit(encodeR(7'h00, 3'b010, 6, 5, 2));
        emit(encodeR(7'h00, 3'b001, 7, 2, 6));
        emit(encodeR(7'h00, 3'b110, 8, 7, 6));
        emit(encodeR(7'h00, 3'b011, 9, 8, 5));
        emit(encodeR(7'h00, 3'b000, 10, 9, 8));
        emit(encodeStore(10, 0, 12'h204));
        emit(encodeR(7'h00, 3'b101, 11, 5, 9));
        emit(encodeStore(11, 0, 12'h208));
        emit(encodeStore(0, 0, DONE_ADDR[11:0]));
        expectStore(32'h200, 32'hECA8_6420);
        expectStore(32'h204, 32'h2468_ACF2);
        expectStore(32'h208, 32'h7654_3210);
        // loads used right away, as operand and as store data
        buildIdx = 1;
        testNames[1] = "loadUse";
        dataInit[1] = '{32'h0000_1234, 32'hFFFF_FF00};
        emit(encodeI(I_ARITH, 3'b000, 1, 0, 12'h100));
        emit(encodeI(I_LOAD, 3'b010, 2, 1, 12'h000));
        emit(encodeR(7'h00, 3'b000, 3, 2, 1));
        emit(encodeStore(3, 0, 12'h200));
        emit(encodeI(I_LOAD, 3'b010, 4, 1, 12'h004));
        emit(encodeStore(4, 0, 12'h204));
        emit(encodeI(I_LOAD, 3'b010, 5, 1, 12'h000));
        emit(encodeI(I_ARITH, 3'b000, 6, 0, 12'h003));
        emit(encodeR(7'h20, 3'b000, 7, 5, 6));
        emit(encodeStore(7, 1, 12'h008));
        emit(encodeI(I_LOAD, 3'b010, 8, 1, 12'h008));
        emit(encodeR(7'h00, 3'b000, 9, 8, 4));
        emit(encodeStore(9, 0, 12'h20C));
        emit(encodeStore(0, 0, DONE_ADDR[11:0]));
        expectStore(32'h200, 32'h0000_1334);
        expectStore(32'h204, 32'hFFFF_FF00);
        expectStore(32'h108, 32'h0000_1231);
        expectStore(32'h20C, 32'h0000_1131);
        // stores to 0x3xx sit on annulled or skipped paths
        buildIdx = 2;
        testNames[2] = "controlFlow";
        dataInit[2] = '{32'h0, 32'h0};
        emit(encodeI(I_ARITH, 3'b000, 1, 0, 12'h005));
        emit(encodeI(I_ARITH, 3'b000, 2, 0, 12'h005));
        emit(encodeBranch(3'b000, 1, 2, 13'd8));
        emit(encodeStore(1, 0, 12'h300));
        emit(encodeBranch(3'b001, 1, 2, 13'd8));
        emit(encodeStore(1, 0, 12'h200));
        // jal at pc 24, link is 28
        emit(encodeJal(3, 21'd12));
        emit(encodeStore(2, 0, 12'h308));
        emit(encodeStore(2, 0, 12'h30C));
        emit(encodeStore(3, 0, 12'h204));
        emit(encodeI(I_ARITH, 3'b000, 4, 0, 12'hFFD));
        emit(encodeBranch(3'b100, 4, 1, 13'd8));
        emit(encodeStore(4, 0, 12'h310));
        emit(encodeBranch(3'b101, 4, 1, 13'd8));
        emit(encodeStore(4, 0, 12'h208));
        emit(encodeStore(0, 0, DONE_ADDR[11:0]));
        expectStore(32'h200, 32'h0000_0005);
        expectStore(32'h204, 32'h0000_001C);
        expectStore(32'h208, 32'hFFFF_FFFD);
        // same programs again under back-pressure
        for (int t = 0; t < NUM_BASE; t++) begin
            gapPcts[t] = 0;
            busyMaxes[t] = 1;
            testNames[t + NUM_BASE] = {testNames[t], "_bp"};
            progs[t + NUM_BASE] = progs[t];
            progLen[t + NUM_BASE] = progLen[t];
            dataInit[t + NUM_BASE] = dataInit[t];
            expAddr[t + NUM_BASE] = expAddr[t];
            expData[t + NUM_BASE] = expData[t];
            expCount[t + NUM_BASE] = expCount[t];
            gapPcts[t + NUM_BASE] = BP_GAP_PCT;
            busyMaxes[t + NUM_BASE] = BP_BUSY_MAX;
        end
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string what, input Word expVal, input Word actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("ERROR %s %s: expected %h, actual %h",
                               testNames[curTest], what, expVal, actVal));
        end
    endtask

    task automatic checkLevel(input string what, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("ERROR %s %s: expected %b, actual %b",
                               testNames[curTest], what, expVal, actVal));
        end
    endtask

    // only the dispatch strobes are defined when idle
    task automatic checkReq(input string what, input DmemReq expVal, input DmemReq actVal);
        if ({actVal.dispatchRead, actVal.dispatchWrite}
                !== {expVal.dispatchRead, expVal.dispatchWrite}) begin
            abortRun($sformatf("ERROR %s %s: expected dispatch %b%b, actual %b%b",
                               testNames[curTest], what, expVal.dispatchRead,
                               expVal.dispatchWrite, actVal.dispatchRead,
                               actVal.dispatchWrite));
        end
    endtask

    //////////////////////////////////////////////////
    // data memory model
    //////////////////////////////////////////////////
    task automatic handleRequest(input DmemReq req, input int busyMax);
        if (req.dispatchWrite === 1'b1) begin
            if (req.addr === DONE_ADDR) begin
                if (storeIdx != expCount[curTest]) begin
                    abortRun($sformatf("test %s finished after %0d stores, %0d were expected",
                                       testNames[curTest], storeIdx, expCount[curTest]));
                end
                doneSeen = 1'b1;
            end else begin
                if (storeIdx >= expCount[curTest]) begin
                    abortRun($sformatf("test %s made an extra store to %h",
                                       testNames[curTest], req.addr));
                end
                checkWord("store address", expAddr[curTest][storeIdx], req.addr);
                checkWord("store data", expData[curTest][storeIdx], req.writeData);
                storeIdx++;
                dmem[req.addr[10:2]] = req.writeData;
            end
        end
        if (req.dispatchRead === 1'b1) begin
            readLatch = dmem[req.addr[10:2]];
        end
        if (req.dispatchRead === 1'b1 || req.dispatchWrite === 1'b1) begin
            busyLeft = 1 + ($urandom % busyMax);
        end
    endtask

    // samples mid-cycle, drives 1 ns after the rising edge
    initial begin : memoryModel
        DmemReq req;
        logic idle;
        int gapPct;
        int busyMax;
        int seedDummy;
        // this process draws every random busy length and gap
        seedDummy = $urandom(28);
        forever begin
            @(negedge clk_in);
            idle = rst_in || doneSeen;
            gapPct = gapPcts[curTest];
            busyMax = busyMaxes[curTest];
            req = dmemReq;
            if (!idle) begin
                handleRequest(req, busyMax);
            end
            @(posedge clk_in);
            #1;
            if (idle) begin
                busyLeft = 0;
                dmemBusy = 1'b0;
                imemValid = 1'b1;
            end else begin
                dmemBusy = (busyLeft > 0);
                // garbage while busy, so early use shows up
                dmemReadData = (busyLeft > 0) ? 32'hDEAD_BEEF : readLatch;
                if (busyLeft > 0) begin
                    busyLeft--;
                end
                imemValid = (gapPct == 0) || (($urandom % 100) >= gapPct);
            end
        end
    end

    task automatic loadMemories(input int t);
        for (int i = 0; i < PROG_WORDS; i++) begin
            imem[i] = progs[t][i];
        end
        // fill word follows its byte address
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'hD0D0_0000 | (i << 2);
        end
        dmem[DATA_BASE[10:2]] = dataInit[t][0];
        dmem[DATA_BASE[10:2] + 1] = dataInit[t][1];
    endtask

    task automatic resetDut(input int t);
        @(posedge clk_in);
        #1;
        rst_in = 1'b1;
        curTest = t;
        storeIdx = 0;
        doneSeen = 1'b0;
        loadMemories(t);
        repeat (2) @(posedge clk_in);
        @(negedge clk_in);
        // no fetch request while in reset
        checkLevel("fetch request in reset", 1'b0, imemReq);
        @(posedge clk_in);
        #1;
        rst_in = 1'b0;
    endtask

    // per-test limit from program length and worst busy length
    initial begin : watchdog
        forever begin
            @(posedge clk_in);
            if (!rst_in && !doneSeen && ($time - testStart > testBudget)) begin
                abortRun($sformatf("test %s hung, no end-marker store after %0t ns",
                                   testNames[curTest], testBudget));
            end
        end
    end

    initial begin : mainSeq
        DmemReq idleReq;
        rst_in = 1'b1;
        imemValid = 1'b0;
        dmemBusy = 1'b0;
        dmemReadData = '0;
        curTest = 0;
        storeIdx = 0;
        busyLeft = 0;
        readLatch = '0;
        doneSeen = 1'b0;
        testStart = 0;
        testBudget = 0;
        idleReq = '0;
        buildTable();
        for (int t = 0; t < NUM_TESTS; t++) begin
            resetDut(t);
            @(negedge clk_in);
            checkReq("request after reset", idleReq, dmemReq);
            checkWord("fetch address after reset", RESET_PC, imemAddr);
            checkLevel("fetch request after reset", 1'b1, imemReq);
            testBudget = progLen[t] * (busyMaxes[t] + REFILL_CYCLES) * CLK_PERIOD * MARGIN;
            testStart = $time;
            wait (doneSeen);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: decodeStage.sv
module decodeStage (
    input  logic             clk_in,
    input  logic             rst_in,
    input  cpuPkg::F2D       f2d,
    input  cpuPkg::Bypass    exBypass,
    input  cpuPkg::Bypass    wbBypass,
    input  logic             redirectValid,
    input  cpuPkg::Word      redirectPc,
    input  logic             exHold,
    output cpuPkg::RegAddr   rdAddr1,
    output cpuPkg::RegAddr   rdAddr2,
    input  cpuPkg::Word      rdData1,
    input  cpuPkg::Word      rdData2,
    output cpuPkg::D2E       d2e,
    output cpuPkg::FetchCmd  fetchCmd
);
    import cpuPkg::*;

    DecodedInst dInst;
    Word rVal1, rVal2;
    logic hazard;

    // newest value wins, execute before writeback
    function automatic Word pickOperand(RegAddr src, Word rfVal, Bypass exB, Bypass wbB);
        Word val;
        val = rfVal;
        if (src != '0 && wbB.dst == src) val = wbB.data;
        if (src != '0 && exB.dst == src) val = exB.data;
        return val;
    endfunction

    // producer found but its data is not there yet
    function automatic logic operandWaits(RegAddr src, Bypass exB, Bypass wbB);
        logic exHit;
        logic wbHit;
        exHit = (src != '0) && (exB.dst == src);
        wbHit = (src != '0) && (wbB.dst == src);
        return (exHit && !exB.dataValid) || (!exHit && wbHit && !wbB.dataValid);
    endfunction

    instrDecoder u_decoder (
        .instr(f2d.instr),
        .dInst(dInst)
    );

    assign rdAddr1 = dInst.src1;
    assign rdAddr2 = dInst.src2;

    //////////////////////////////////////////////////
    // forwarding and load-use hazard
    //////////////////////////////////////////////////
    assign rVal1 = pickOperand(dInst.src1, rdData1, exBypass, wbBypass);
    assign rVal2 = pickOperand(dInst.src2, rdData2, exBypass, wbBypass);
    assign hazard = f2d.valid && (operandWaits(dInst.src1, exBypass, wbBypass)
                               || operandWaits(dInst.src2, exBypass, wbBypass));

    // fetch command, annul beats everything
    always_comb begin
        if (redirectValid) begin
            fetchCmd = '{action: REDIRECT, redirectPc: redirectPc};
        end else if (hazard || exHold || !f2d.valid) begin
            fetchCmd = '{action: STALL, redirectPc: redirectPc};
        end else begin
            fetchCmd = '{action: DEQUEUE, redirectPc: redirectPc};
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            d2e.valid <= 1'b0;
        end else if (!exHold) begin
            if (redirectValid || hazard || !f2d.valid) begin
                // bubble
                d2e.valid <= 1'b0;
            end else begin
                d2e <= '{pc: f2d.pc, dInst: dInst, rVal1: rVal1, rVal2: rVal2, valid: 1'b1};
            end
        end
    end

endmodule

// File: executeStage.sv
module executeStage (
    input  logic            clk_in,
    input  logic            rst_in,
    input  cpuPkg::D2E      d2e,
    input  logic            dmemBusy,
    input  logic            wbStall,
    output cpuPkg::DmemReq  dmemReq,
    output cpuPkg::E2W      e2w,
    output cpuPkg::Bypass   exBypass,
    output logic            redirectValid,
    output cpuPkg::Word     redirectPc,
    output logic            exHold
);
    import cpuPkg::*;

    DecodedInst dI;
    Word aluB, aluOut, linkPc, nextPc, result;
    logic brTaken, memOp, memStall, canDispatch;

    assign dI = d2e.dInst;
    assign aluB = (dI.iType == ALU) ? d2e.rVal2 : dI.imm;

    //////////////////////////////////////////////////
    // alu and branch
    //////////////////////////////////////////////////
    always_comb begin
        case (dI.aluFunc)
            ALU_ADD:  aluOut = d2e.rVal1 + aluB;
            ALU_SUB:  aluOut = d2e.rVal1 - aluB;
            ALU_AND:  aluOut = d2e.rVal1 & aluB;
            ALU_OR:   aluOut = d2e.rVal1 | aluB;
            ALU_XOR:  aluOut = d2e.rVal1 ^ aluB;
            ALU_SLT:  aluOut = Word'($signed(d2e.rVal1) < $signed(aluB));
            ALU_SLTU: aluOut = Word'(d2e.rVal1 < aluB);
            ALU_SLL:  aluOut = d2e.rVal1 << aluB[4:0];
            ALU_SRL:  aluOut = d2e.rVal1 >> aluB[4:0];
            ALU_SRA:  aluOut = Word'($signed(d2e.rVal1) >>> aluB[4:0]);
            default:  aluOut = d2e.rVal1 + aluB;
        endcase
    end

    always_comb begin
        case (dI.brFunc)
            BR_EQ:   brTaken = (d2e.rVal1 == d2e.rVal2);
            BR_NE:   brTaken = (d2e.rVal1 != d2e.rVal2);
            BR_LT:   brTaken = ($signed(d2e.rVal1) < $signed(d2e.rVal2));
            default: brTaken = ($signed(d2e.rVal1) >= $signed(d2e.rVal2));
        endcase
    end

    assign linkPc = d2e.pc + PC_STEP;
    assign nextPc = (dI.iType == JAL || (dI.iType == BRANCH && brTaken))
                  ? d2e.pc + dI.imm : linkPc;

    always_comb begin
        case (dI.iType)
            LUI:       result = dI.imm;
            JAL:       result = linkPc;
            ALU, ALUI: result = aluOut;
            // load data arrives in writeback
            default:   result = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // data memory and hold
    //////////////////////////////////////////////////
    assign memOp = d2e.valid && (dI.iType == LOAD || dI.iType == STORE);
    assign memStall = memOp && dmemBusy;
    assign exHold = memStall || wbStall;
    // dispatch only when the op can move into e2w
    assign canDispatch = memOp && !dmemBusy && !wbStall;

    assign dmemReq = '{addr: d2e.rVal1 + dI.imm, writeData: d2e.rVal2,
                       dispatchRead: canDispatch && dI.iType == LOAD,
                       dispatchWrite: canDispatch && dI.iType == STORE};

    // predicted not taken, so any other next pc annuls
    assign redirectValid = d2e.valid && !exHold && (nextPc != linkPc);
    assign redirectPc = nextPc;

    assign exBypass = '{dst: d2e.valid ? dI.dst : '0, data: result,
                        dataValid: dI.iType != LOAD};

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            e2w.valid <= 1'b0;
        end else if (!wbStall) begin
            if (memStall || !d2e.valid) begin
                e2w.valid <= 1'b0;
            end else begin
                e2w <= '{iType: dI.iType, dst: dI.dst, data: result, valid: 1'b1};
            end
        end
    end

    // memory answers every dispatch with busy on the next cycle
    busyAfterDispatch: assert property (@(posedge clk_in) disable iff (rst_in)
        (dmemReq.dispatchRead || dmemReq.dispatchWrite) |=> dmemBusy);

    // younger instruction annulled behind a redirect
    annulBubble: assert property (@(posedge clk_in) disable iff (rst_in)
        redirectValid |=> !d2e.valid);

endmodule

// File: fetchStage.sv
module fetchStage (
    input  logic             clk_in,
    input  logic             rst_in,
    input  cpuPkg::FetchCmd  fetchCmd,
    input  cpuPkg::Word      imemInstr,
    input  logic             imemValid,
    output cpuPkg::Word      imemAddr,
    output logic             imemReq,
    output cpuPkg::F2D       f2d
);
    import cpuPkg::*;

    Word pc;
    logic slotFree;

    // memory answers for the current pc in the same cycle
    assign imemAddr = pc;
    assign imemReq = !rst_in;

    // an empty slot may be refilled even while decode stalls
    assign slotFree = (fetchCmd.action == DEQUEUE) || !f2d.valid;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pc <= RESET_PC;
            f2d.valid <= 1'b0;
        end else if (fetchCmd.action == REDIRECT) begin
            // drop whatever sits in the slot
            pc <= fetchCmd.redirectPc;
            f2d <= '{pc: fetchCmd.redirectPc, instr: NOP_INSTR, valid: 1'b0};
        end else if (slotFree) begin
            if (imemValid) begin
                f2d <= '{pc: pc, instr: imemInstr, valid: 1'b1};
                pc <= pc + PC_STEP;
            end else begin
                // instruction not ready, bubble
                f2d <= '{pc: pc, instr: NOP_INSTR, valid: 1'b0};
            end
        end
        // STALL on a full slot holds pc and f2d
    end

    // redirect targets must stay word aligned
    addrAligned: assert property (@(posedge clk_in) disable iff (rst_in)
        imemAddr[1:0] == 2'b00);

endmodule

// File: files.f
cpuPkg.sv
fetchStage.sv
instrDecoder.sv
regFile.sv
decodeStage.sv
executeStage.sv
writebackStage.sv
pipelineCpu.sv
cpuTb.sv

// File: instrDecoder.sv
module instrDecoder (
    input  cpuPkg::Word         instr,
    output cpuPkg::DecodedInst  dInst
);
    import cpuPkg::*;

    Opcode opc;
    logic [2:0] f3;
    logic altBit;
    logic f7Ok;
    Word immI, immS, immB, immU, immJ;

    // funct3 to alu op, altBit picks sub / sra
    function automatic AluFunc aluOf(logic [2:0] fn3, logic alt);
        case (fn3)
            3'd0: return alt ? ALU_SUB : ALU_ADD;
            3'd1: return ALU_SLL;
            3'd2: return ALU_SLT;
            3'd3: return ALU_SLTU;
            3'd4: return ALU_XOR;
            3'd5: return alt ? ALU_SRA : ALU_SRL;
            3'd6: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opc = Opcode'(instr[6:0]);
    assign f3 = instr[14:12];
    assign altBit = instr[30];
    // funct7 of 0x00 or 0x20 only
    assign f7Ok = !instr[31] && (instr[29:25] == 5'd0);

    // immediates, all sign extended from bit 31
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // default is a no-op writing nothing
        dInst = '{iType: UNSUPPORTED, aluFunc: ALU_ADD, brFunc: BR_EQ,
                  dst: '0, src1: '0, src2: '0, imm: '0};
        case (opc)
            OPC_OP: if (f7Ok) begin
                dInst = '{iType: ALU, aluFunc: aluOf(f3, altBit), brFunc: BR_EQ,
                          dst: instr[11:7], src1: instr[19:15], src2: instr[24:20], imm: '0};
            end
            OPC_OP_IMM: begin
                // only srai takes the alt bit
                dInst = '{iType: ALUI, aluFunc: aluOf(f3, altBit && f3 == 3'd5),
                          brFunc: BR_EQ, dst: instr[11:7], src1: instr[19:15], src2: '0,
                          imm: immI};
            end
            OPC_LUI: dInst = '{iType: LUI, aluFunc: ALU_ADD, brFunc: BR_EQ,
                               dst: instr[11:7], src1: '0, src2: '0, imm: immU};
            OPC_JAL: dInst = '{iType: JAL, aluFunc: ALU_ADD, brFunc: BR_EQ,
                               dst: instr[11:7], src1: '0, src2: '0, imm: immJ};
            OPC_BRANCH: if (f3 inside {3'd0, 3'd1, 3'd4, 3'd5}) begin
                // f3 {0,1,4,5} folds onto EQ NE LT GE
                dInst = '{iType: BRANCH, aluFunc: ALU_ADD, brFunc: BrFunc'({f3[2], f3[0]}),
                          dst: '0, src1: instr[19:15], src2: instr[24:20], imm: immB};
            end
            OPC_LOAD: if (f3 == 3'd2) begin
                dInst = '{iType: LOAD, aluFunc: ALU_ADD, brFunc: BR_EQ,
                          dst: instr[11:7], src1: instr[19:15], src2: '0, imm: immI};
            end
            OPC_STORE: if (f3 == 3'd2) begin
                dInst = '{iType: STORE, aluFunc: ALU_ADD, brFunc: BR_EQ,
                          dst: '0, src1: instr[19:15], src2: instr[24:20], imm: immS};
            end
            default: ;
        endcase
    end

endmodule

// File: pipelineCpu.sv
module pipelineCpu (
    input  logic            clk_in,
    input  logic            rst_in,
    output cpuPkg::Word     imemAddr,
    output logic            imemReq,
    input  cpuPkg::Word     imemInstr,
    input  logic            imemValid,
    output cpuPkg::DmemReq  dmemReq,
    input  logic            dmemBusy,
    input  cpuPkg::Word     dmemReadData
);
    import cpuPkg::*;

    // stage to stage
    FetchCmd fetchCmd;
    F2D f2d;
    D2E d2e;
    E2W e2w;

    // bypass and control back to decode
    Bypass exBypass;
    Bypass wbBypass;
    logic redirectValid;
    Word redirectPc;
    logic exHold;
    logic wbStall;

    // register file ports
    RegAddr rdAddr1, rdAddr2;
    Word rdData1, rdData2;
    RfWrite rfWrite;

    fetchStage u_fetch (.*);

    decodeStage u_decode (.*);

    regFile u_regFile (.*);

    executeStage u_execute (.*);

    writebackStage u_writeback (.*);

endmodule

// File: regFile.sv
module regFile (
    input  logic            clk_in,
    input  logic            rst_in,
    input  cpuPkg::RegAddr  rdAddr1,
    input  cpuPkg::RegAddr  rdAddr2,
    output cpuPkg::Word     rdData1,
    output cpuPkg::Word     rdData2,
    input  cpuPkg::RfWrite  rfWrite
);
    import cpuPkg::*;

    Word regs [REG_COUNT];

    // x0 is hardwired
    assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rfWrite.en && rfWrite.addr != '0) begin
            regs[rfWrite.addr] <= rfWrite.data;
        end
    end

endmodule

// File: writebackStage.sv
module writebackStage (
    input  logic            clk_in,
    input  logic            rst_in,
    input  cpuPkg::E2W      e2w,
    input  logic            dmemBusy,
    input  cpuPkg::Word     dmemReadData,
    output cpuPkg::RfWrite  rfWrite,
    output cpuPkg::Bypass   wbBypass,
    output logic            wbStall
);
    import cpuPkg::*;

    logic isLoad;
    logic wrEn;
    Word wrData;

    assign isLoad = e2w.valid && (e2w.iType == LOAD);
    // load still outstanding
    assign wbStall = isLoad && dmemBusy;

    // read data valid once busy drops
    assign wrData = isLoad ? dmemReadData : e2w.data;
    assign wrEn = e2w.valid && (e2w.dst != '0) && !wbStall;

    assign rfWrite = '{en: wrEn, addr: e2w.dst, data: wrData};

    // same-cycle value, register file only has it next cycle
    assign wbBypass = '{dst: e2w.valid ? e2w.dst : '0, data: wrData, dataValid: !wbStall};

    // waiting load stays frozen in e2w
    e2wHeld: assert property (@(posedge clk_in) disable iff (rst_in)
        wbStall |=> $stable(e2w));

endmodule
